// File: rtl/atop_pkg.sv
package atop_pkg;

  // Channel widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  // Burst length minus one
  typedef logic [7:0]           len_t;
  typedef logic [1:0]           resp_t;
  typedef logic [5:0]           atop_t;

  // Response codes
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlverr = 2'b10;

  // Atop bit that asks for read data back
  localparam int unsigned AtopRRespBit = 5;

  // Atomic when atop[5:4] is not the plain-write encoding
  function automatic logic is_atomic(atop_t atop);
    return atop[5:4] != 2'b00;
  endfunction

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    atop_t atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

endpackage

// File: rtl/write_burst_tracker.sv
module write_burst_tracker #(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_fire_i,
  input  logic w_last_fire_i,
  output logic aw_pending_o,
  output logic w_ahead_o,
  output logic aw_room_o
);

  // Two bits minimum so that -1 is distinct from the limit
  localparam int unsigned CntWidth = (MaxWriteTxns == 1) ? 2 : $clog2(MaxWriteTxns + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  typedef struct packed {
    logic underflow;
    cnt_t cnt;
  } burst_cnt_t;

  localparam cnt_t CntMax = cnt_t'(MaxWriteTxns);

  burst_cnt_t cnt_d, cnt_q;

  // Positive count means AWs still waiting for W data
  assign aw_pending_o = !cnt_q.underflow && (cnt_q.cnt != '0);
  // Count of -1 means one full W burst went ahead
  assign w_ahead_o    = cnt_q.underflow && (&cnt_q.cnt);
  // A W burst ahead always has room for its own AW
  assign aw_room_o    = w_ahead_o || (cnt_q.cnt < CntMax);

  always_comb begin
    cnt_d = cnt_q;
    case ({aw_fire_i, w_last_fire_i})
      2'b10:   cnt_d.cnt = cnt_q.cnt + cnt_t'(1);
      2'b01:   cnt_d.cnt = cnt_q.cnt - cnt_t'(1);
      default: cnt_d.cnt = cnt_q.cnt;
    endcase
    // Leaving -1 back to zero, or wrapping from zero to -1
    if (cnt_q.underflow && (cnt_d.cnt == '0)) begin
      cnt_d.underflow = 1'b0;
    end else if ((cnt_q.cnt == '0) && (&cnt_d.cnt)) begin
      cnt_d.underflow = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: rtl/write_atop_ctrl.sv
module write_atop_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  atop_pkg::axi_req_t slv_req_i,
  input  logic               mst_aw_ready_i,
  input  logic               mst_w_ready_i,
  input  logic               mst_b_valid_i,
  input  atop_pkg::b_chan_t  mst_b_i,
  input  logic               aw_pending_i,
  input  logic               w_ahead_i,
  input  logic               aw_room_i,
  input  logic               rcmd_busy_i,
  output atop_pkg::aw_chan_t mst_aw_o,
  output logic               mst_aw_valid_o,
  output logic               mst_w_valid_o,
  output logic               mst_b_ready_o,
  output logic               slv_aw_ready_o,
  output logic               slv_w_ready_o,
  output logic               slv_b_valid_o,
  output atop_pkg::b_chan_t  slv_b_o,
  output logic               rcmd_valid_o,
  output atop_pkg::len_t     rcmd_len_o,
  output atop_pkg::id_t      atop_id_o
);
  import atop_pkg::*;

  typedef enum logic [2:0] {
    W_FEEDTHROUGH,
    W_BLOCK_AW,
    W_ABSORB_W,
    W_HOLD_B,
    W_INJECT_B,
    W_WAIT_R
  } w_state_e;

  w_state_e w_state_d, w_state_q;
  w_state_e w_done_state;
  id_t      id_d, id_q;
  logic     aw_atomic;
  logic     w_last_valid;
  logic     b_stalled;

  assign aw_atomic    = slv_req_i.aw_valid && is_atomic(slv_req_i.aw.atop);
  assign w_last_valid = slv_req_i.w_valid && slv_req_i.w.last;
  // Forwarded B waiting upstream, must finish before injection
  assign b_stalled    = mst_b_valid_i && !slv_req_i.b_ready;
  assign w_done_state = b_stalled ? W_HOLD_B : W_INJECT_B;

  // Forwarded AW never carries an atop
  always_comb begin
    mst_aw_o      = slv_req_i.aw;
    mst_aw_o.atop = '0;
  end

  assign rcmd_len_o = slv_req_i.aw.len;
  assign atop_id_o  = id_q;

  always_comb begin
    // AW and W closed unless a state opens them
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // B passes through by default
    mst_b_ready_o  = slv_req_i.b_ready;
    slv_b_valid_o  = mst_b_valid_i;
    slv_b_o        = mst_b_i;
    rcmd_valid_o   = 1'b0;
    id_d           = id_q;
    w_state_d      = w_state_q;

    case (w_state_q)
      W_FEEDTHROUGH: begin
        // Forward AW only below the burst limit
        if (aw_room_i) begin
          mst_aw_valid_o = slv_req_i.aw_valid;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W goes down for an open AW, or for a plain AW not already covered
        if (aw_pending_i ||
            (slv_req_i.aw_valid && !is_atomic(slv_req_i.aw.atop) && !w_ahead_i)) begin
          mst_w_valid_o = slv_req_i.w_valid;
          slv_w_ready_o = mst_w_ready_i;
        end
        if (aw_atomic) begin
          // Take the atomic AW here, keep it off the downstream port
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          id_d           = slv_req_i.aw.id;
          // Read data requested, hand a command to the R side
          rcmd_valid_o   = slv_req_i.aw.atop[AtopRRespBit];
          if (aw_pending_i) begin
            // Earlier W bursts still owed downstream
            w_state_d = W_BLOCK_AW;
          end else begin
            mst_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            w_state_d     = w_last_valid ? w_done_state : W_ABSORB_W;
          end
        end
      end

      W_BLOCK_AW: begin
        if (aw_pending_i) begin
          // Drain outstanding W bursts first
          mst_w_valid_o = slv_req_i.w_valid;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          // Now the upstream W is the atomic burst
          slv_w_ready_o = 1'b1;
          w_state_d     = w_last_valid ? w_done_state : W_ABSORB_W;
        end
      end

      W_ABSORB_W: begin
        // Swallow the atomic W beats
        slv_w_ready_o = 1'b1;
        if (w_last_valid) begin
          w_state_d = w_done_state;
        end
      end

      W_HOLD_B: begin
        // Wait for the forwarded B handshake
        if (mst_b_valid_i && slv_req_i.b_ready) begin
          w_state_d = W_INJECT_B;
        end
      end

      W_INJECT_B: begin
        // Downstream B paused while the error response goes up
        mst_b_ready_o  = 1'b0;
        slv_b_valid_o  = 1'b1;
        slv_b_o.id     = id_q;
        slv_b_o.resp   = RespSlverr;
        if (slv_req_i.b_ready) begin
          w_state_d = rcmd_busy_i ? W_WAIT_R : W_FEEDTHROUGH;
        end
      end

      W_WAIT_R: begin
        // Injected R beats still going out
        if (!rcmd_busy_i) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end

      default: w_state_d = W_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_FEEDTHROUGH;
    end else begin
      w_state_q <= w_state_d;
    end
  end

  // Atomic ID for the injected B and R
  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end

endmodule

// File: rtl/read_resp_injector.sv
module read_resp_injector (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rcmd_valid_i,
  input  atop_pkg::len_t    rcmd_len_i,
  input  atop_pkg::id_t     atop_id_i,
  input  logic              mst_r_valid_i,
  input  atop_pkg::r_chan_t mst_r_i,
  input  logic              slv_r_ready_i,
  output logic              rcmd_busy_o,
  output logic              mst_r_ready_o,
  output logic              slv_r_valid_o,
  output atop_pkg::r_chan_t slv_r_o
);
  import atop_pkg::*;

  typedef enum logic [1:0] {
    R_FEEDTHROUGH,
    R_INJECT,
    R_HOLD
  } r_state_e;

  r_state_e r_state_d, r_state_q;
  // Single command slot, beats left minus one
  logic     cmd_pending_d, cmd_pending_q;
  len_t     beats_d, beats_q;
  logic     last_beat;

  assign rcmd_busy_o = cmd_pending_q;
  assign last_beat   = (beats_q == '0);

  always_comb begin
    // R passes through by default
    mst_r_ready_o = slv_r_ready_i;
    slv_r_valid_o = mst_r_valid_i;
    slv_r_o       = mst_r_i;
    cmd_pending_d = cmd_pending_q;
    beats_d       = beats_q;
    r_state_d     = r_state_q;

    // Load a new command, only arrives when the slot is empty
    if (rcmd_valid_i) begin
      cmd_pending_d = 1'b1;
      beats_d       = rcmd_len_i;
    end

    case (r_state_q)
      R_FEEDTHROUGH: begin
        if (mst_r_valid_i && !slv_r_ready_i) begin
          // Forwarded beat stalled, payload must stay put
          r_state_d = R_HOLD;
        end else if (cmd_pending_q) begin
          r_state_d = R_INJECT;
        end
      end

      R_INJECT: begin
        // Downstream R paused
        mst_r_ready_o = 1'b0;
        slv_r_valid_o = 1'b1;
        slv_r_o       = '0;
        slv_r_o.id    = atop_id_i;
        slv_r_o.resp  = RespSlverr;
        slv_r_o.last  = last_beat;
        if (slv_r_ready_i) begin
          if (last_beat) begin
            cmd_pending_d = 1'b0;
            r_state_d     = R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - len_t'(1);
          end
        end
      end

      R_HOLD: begin
        // Back once the stalled beat is taken
        if (mst_r_valid_i && slv_r_ready_i) begin
          r_state_d = R_FEEDTHROUGH;
        end
      end

      default: r_state_d = R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q     <= R_FEEDTHROUGH;
      cmd_pending_q <= 1'b0;
      beats_q       <= '0;
    end else begin
      r_state_q     <= r_state_d;
      cmd_pending_q <= cmd_pending_d;
      beats_q       <= beats_d;
    end
  end

endmodule

// File: rtl/atop_filter.sv
module atop_filter #(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  atop_pkg::axi_req_t slv_req_i,
  output atop_pkg::axi_rsp_t slv_rsp_o,
  output atop_pkg::axi_req_t mst_req_o,
  input  atop_pkg::axi_rsp_t mst_rsp_i
);
  import atop_pkg::*;

  // Write side, from the controller
  aw_chan_t mst_aw;
  logic     mst_aw_valid;
  logic     mst_w_valid;
  logic     mst_b_ready;
  logic     slv_aw_ready;
  logic     slv_w_ready;
  logic     slv_b_valid;
  b_chan_t  slv_b;

  // Read side, from the injector
  logic     mst_r_ready;
  logic     slv_r_valid;
  r_chan_t  slv_r;

  // Tracker strobes and status
  logic     aw_fire;
  logic     w_last_fire;
  logic     aw_pending;
  logic     w_ahead;
  logic     aw_room;

  // Read injection command
  logic     rcmd_valid;
  logic     rcmd_busy;
  len_t     rcmd_len;
  id_t      atop_id;

  // Handshakes seen on the downstream port
  assign aw_fire     = mst_aw_valid && mst_rsp_i.aw_ready;
  assign w_last_fire = mst_w_valid && mst_rsp_i.w_ready && slv_req_i.w.last;

  // Downstream request
  always_comb begin
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = slv_req_i.w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    // AR goes straight through
    mst_req_o.ar       = slv_req_i.ar;
    mst_req_o.ar_valid = slv_req_i.ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  // Upstream response
  always_comb begin
    slv_rsp_o.aw_ready = slv_aw_ready;
    slv_rsp_o.w_ready  = slv_w_ready;
    slv_rsp_o.b        = slv_b;
    slv_rsp_o.b_valid  = slv_b_valid;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready;
    slv_rsp_o.r        = slv_r;
    slv_rsp_o.r_valid  = slv_r_valid;
  end

  write_burst_tracker #(
    .MaxWriteTxns(MaxWriteTxns)
  ) u_write_burst_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_fire_i    (aw_fire),
    .w_last_fire_i(w_last_fire),
    .aw_pending_o (aw_pending),
    .w_ahead_o    (w_ahead),
    .aw_room_o    (aw_room)
  );

  write_atop_ctrl u_write_atop_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_req_i     (slv_req_i),
    .mst_aw_ready_i(mst_rsp_i.aw_ready),
    .mst_w_ready_i (mst_rsp_i.w_ready),
    .mst_b_valid_i (mst_rsp_i.b_valid),
    .mst_b_i       (mst_rsp_i.b),
    .aw_pending_i  (aw_pending),
    .w_ahead_i     (w_ahead),
    .aw_room_i     (aw_room),
    .rcmd_busy_i   (rcmd_busy),
    .mst_aw_o      (mst_aw),
    .mst_aw_valid_o(mst_aw_valid),
    .mst_w_valid_o (mst_w_valid),
    .mst_b_ready_o (mst_b_ready),
    .slv_aw_ready_o(slv_aw_ready),
    .slv_w_ready_o (slv_w_ready),
    .slv_b_valid_o (slv_b_valid),
    .slv_b_o       (slv_b),
    .rcmd_valid_o  (rcmd_valid),
    .rcmd_len_o    (rcmd_len),
    .atop_id_o     (atop_id)
  );

  read_resp_injector u_read_resp_injector (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rcmd_valid_i (rcmd_valid),
    .rcmd_len_i   (rcmd_len),
    .atop_id_i    (atop_id),
    .mst_r_valid_i(mst_rsp_i.r_valid),
    .mst_r_i      (mst_rsp_i.r),
    .slv_r_ready_i(slv_req_i.r_ready),
    .rcmd_busy_o  (rcmd_busy),
    .mst_r_ready_o(mst_r_ready),
    .slv_r_valid_o(slv_r_valid),
    .slv_r_o      (slv_r)
  );

endmodule

// File: testbench/tb_sub_model.sv
module tb_sub_model #(
  parameter int unsigned MaxOut = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  atop_pkg::axi_req_t req_i,
  output atop_pkg::axi_rsp_t rsp_o,
  output int                 aw_count_o,
  output int                 err_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import atop_pkg::*;

  // AWs still waiting for their W burst
  id_t      aw_ids[$];
  // B responses ready to go, in completion order
  id_t      b_ids[$];
  ar_chan_t ars[$];
  // Complete W bursts seen before their AW
  int       w_ahead;
  int       beat;

  initial begin
    rsp_o      = '0;
    aw_count_o = 0;
    err_o      = 0;
    w_ahead    = 0;
    beat       = 0;
    // Quiet until reset is released
    wait (rst_ni);
    forever begin
      @(negedge clk_i);
      // Random readies, valids follow the queues
      rsp_o.aw_ready = ($urandom % 4) != 0;
      rsp_o.w_ready  = ($urandom % 4) != 0;
      rsp_o.ar_ready = ($urandom % 4) != 0;
      rsp_o.b_valid  = b_ids.size() != 0;
      rsp_o.b        = '0;
      if (rsp_o.b_valid) begin
        rsp_o.b.id   = b_ids[0];
        rsp_o.b.resp = RespOkay;
      end
      rsp_o.r_valid = ars.size() != 0;
      rsp_o.r       = '0;
      if (rsp_o.r_valid) begin
        // Read data is address plus beat index
        rsp_o.r.id   = ars[0].id;
        rsp_o.r.data = ars[0].addr + data_t'(beat);
        rsp_o.r.resp = RespOkay;
        rsp_o.r.last = beat == int'(ars[0].len);
      end
      // Sample just before the rising edge
      #4;
      if (req_i.b_ready && rsp_o.b_valid) begin
        void'(b_ids.pop_front());
      end
      if (req_i.r_ready && rsp_o.r_valid) begin
        if (rsp_o.r.last) begin
          void'(ars.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        aw_count_o++;
        if (req_i.aw.atop != '0) begin
          err_o++;
          $display("[FAIL] %0t: AW at master port with atop %h", $time, req_i.aw.atop);
        end
        if (w_ahead > 0) begin
          w_ahead--;
          b_ids.push_back(req_i.aw.id);
        end else begin
          aw_ids.push_back(req_i.aw.id);
        end
      end
      if (req_i.w_valid && rsp_o.w_ready && req_i.w.last) begin
        if (aw_ids.size() > 0) begin
          b_ids.push_back(aw_ids.pop_front());
        end else begin
          w_ahead++;
        end
      end
      // Outstanding write bursts against the limit
      if (aw_ids.size() > int'(MaxOut)) begin
        err_o++;
        $display("[FAIL] %0t: %0d AWs without W data, limit %0d", $time, aw_ids.size(),
                 MaxOut);
      end
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        ars.push_back(req_i.ar);
      end
    end
  end

endmodule

// File: testbench/tb_atop_filter.sv
module tb_atop_filter;
  timeunit 1ns;
  timeprecision 1ps;
  import atop_pkg::*;

  localparam int unsigned MaxWriteTxns = 4;
  localparam int          Timeout      = 5000;

  typedef struct packed {
    resp_t resp;
    data_t data;
    int    beats;
  } ref_t;

  // Expected R burst, atop zero for plain reads
  typedef struct packed {
    atop_t atop;
    addr_t addr;
    len_t  len;
  } rexp_t;

  logic     clk_i;
  logic     rst_ni;
  axi_req_t slv_req;
  axi_rsp_t slv_rsp;
  axi_req_t mst_req;
  axi_rsp_t mst_rsp;

  // Upstream channel drivers
  aw_chan_t aw_s;
  logic     aw_valid;
  w_chan_t  w_s;
  logic     w_valid;
  ar_chan_t ar_s;
  logic     ar_valid;
  logic     b_ready;
  logic     r_ready;

  // Stimulus lists and per-ID expectations
  aw_chan_t aw_list[$];
  ar_chan_t ar_list[$];
  aw_chan_t w_aws[$];
  atop_t    exp_b[16][$];
  rexp_t    exp_r[16][$];
  // Plain AWs and W beats expected at the master port, in order
  aw_chan_t down_aw[$];
  w_chan_t  down_w[$];
  int       r_beat[16];
  int       atomic_left[16];
  int       pending_b;
  int       pending_r;
  int       errors;
  int       model_errors;
  int       aw_count;
  int       aw_before;

  always_comb begin
    slv_req          = '0;
    slv_req.aw       = aw_s;
    slv_req.aw_valid = aw_valid;
    slv_req.w        = w_s;
    slv_req.w_valid  = w_valid;
    slv_req.b_ready  = b_ready;
    slv_req.ar       = ar_s;
    slv_req.ar_valid = ar_valid;
    slv_req.r_ready  = r_ready;
  end

  always #5 clk_i = ~clk_i;

  atop_filter #(
    .MaxWriteTxns(MaxWriteTxns)
  ) u_atop_filter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .slv_req_i(slv_req),
    .slv_rsp_o(slv_rsp),
    .mst_req_o(mst_req),
    .mst_rsp_i(mst_rsp)
  );

  tb_sub_model #(
    .MaxOut(MaxWriteTxns)
  ) u_sub_model (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (mst_req),
    .rsp_o     (mst_rsp),
    .aw_count_o(aw_count),
    .err_o     (model_errors)
  );

  // Expected response for a write (B) or one read beat
  function automatic ref_t reference(input logic is_read, input atop_t atop, input addr_t addr,
                                     input len_t len, input int beat);
    ref_t r;
    logic atomic;
    atomic  = atop[5:4] != 2'b00;
    r.beats = int'(len) + 1;
    r.data  = '0;
    r.resp  = atomic ? RespSlverr : RespOkay;
    if (is_read && !atomic) begin
      r.data = addr + data_t'(beat);
    end
    return r;
  endfunction

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("errors: %0d in checks, %0d in model", errors, model_errors);
    $display("tests failed");
    $finish;
  endtask

  task automatic check_b(input b_chan_t b);
    ref_t  r;
    atop_t atop;
    if (exp_b[b.id].size() == 0) begin
      errors++;
      $display("[FAIL] %0t: unexpected B with id %0d", $time, b.id);
    end else begin
      atop = exp_b[b.id].pop_front();
      r    = reference(1'b0, atop, '0, '0, 0);
      if (b.resp != r.resp) begin
        errors++;
        $display("[FAIL] %0t: B id %0d resp %b, expected %b", $time, b.id, b.resp, r.resp);
      end
      pending_b--;
      if (atop[5:4] != 2'b00) begin
        atomic_left[b.id]--;
      end
    end
  endtask

  task automatic check_r(input r_chan_t rb);
    ref_t  r;
    rexp_t e;
    logic  last_exp;
    if (exp_r[rb.id].size() == 0) begin
      errors++;
      $display("[FAIL] %0t: unexpected R with id %0d", $time, rb.id);
    end else begin
      e        = exp_r[rb.id][0];
      r        = reference(1'b1, e.atop, e.addr, e.len, r_beat[rb.id]);
      last_exp = r_beat[rb.id] == r.beats - 1;
      if (rb.resp != r.resp || rb.data != r.data || rb.last != last_exp) begin
        errors++;
        $display("[FAIL] %0t: R id %0d beat %0d got %b/%h/%b, expected %b/%h/%b", $time,
                 rb.id, r_beat[rb.id], rb.resp, rb.data, rb.last, r.resp, r.data, last_exp);
      end
      r_beat[rb.id]++;
      if (last_exp) begin
        void'(exp_r[rb.id].pop_front());
        r_beat[rb.id] = 0;
        pending_r--;
        if (e.atop[5:4] != 2'b00) begin
          atomic_left[rb.id]--;
        end
      end
    end
  endtask

  task automatic check_down_aw(input aw_chan_t aw);
    aw_chan_t e;
    if (down_aw.size() == 0) begin
      errors++;
      $display("[FAIL] %0t: unexpected AW at master port with id %0d", $time, aw.id);
    end else begin
      e = down_aw.pop_front();
      if (aw != e) begin
        errors++;
        $display("[FAIL] %0t: master AW %h, expected %h", $time, aw, e);
      end
    end
  endtask

  task automatic check_down_w(input w_chan_t w);
    w_chan_t e;
    if (down_w.size() == 0) begin
      errors++;
      $display("[FAIL] %0t: unexpected W beat at master port", $time);
    end else begin
      e = down_w.pop_front();
      if (w != e) begin
        errors++;
        $display("[FAIL] %0t: master W %h, expected %h", $time, w, e);
      end
    end
  endtask

  // Comparing process with random upstream readies
  initial begin
    wait (rst_ni);
    forever begin
      @(negedge clk_i);
      b_ready = ($urandom % 4) != 0;
      r_ready = ($urandom % 4) != 0;
      #4;
      if (slv_rsp.b_valid && b_ready) begin
        check_b(slv_rsp.b);
      end
      if (slv_rsp.r_valid && r_ready) begin
        check_r(slv_rsp.r);
      end
      if (mst_req.aw_valid && mst_rsp.aw_ready) begin
        check_down_aw(mst_req.aw);
      end
      if (mst_req.w_valid && mst_rsp.w_ready) begin
        check_down_w(mst_req.w);
      end
    end
  end

  task automatic drive_aws(input int n);
    aw_chan_t c;
    int       t;
    for (int i = 0; i < n; i++) begin
      c = aw_list[i];
      // One atomic per ID in flight
      t = 0;
      while (atomic_left[c.id] != 0) begin
        @(negedge clk_i);
        t++;
        if (t > Timeout) abort_run("a free atomic ID");
      end
      exp_b[c.id].push_back(c.atop);
      pending_b++;
      if (c.atop[5:4] != 2'b00) begin
        atomic_left[c.id] = c.atop[AtopRRespBit] ? 2 : 1;
        if (c.atop[AtopRRespBit]) begin
          exp_r[c.id].push_back({c.atop, addr_t'(0), c.len});
          pending_r++;
        end
      end else begin
        down_aw.push_back(c);
      end
      w_aws.push_back(c);
      aw_s     = c;
      aw_valid = 1'b1;
      t = 0;
      #4;
      while (!slv_rsp.aw_ready) begin
        t++;
        if (t > Timeout) abort_run("AW ready");
        @(negedge clk_i);
        #4;
      end
      @(negedge clk_i);
      aw_valid = 1'b0;
      repeat ($urandom % 3) @(negedge clk_i);
    end
  endtask

  task automatic drive_ws(input int n);
    aw_chan_t c;
    logic     atomic;
    int       t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (w_aws.size() == 0) begin
        @(negedge clk_i);
        t++;
        if (t > Timeout) abort_run("an AW for the next W burst");
      end
      c      = w_aws.pop_front();
      atomic = c.atop[5:4] != 2'b00;
      for (int b = 0; b <= int'(c.len); b++) begin
        w_s.data = $urandom;
        w_s.strb = '1;
        w_s.last = b == int'(c.len);
        w_valid  = 1'b1;
        // Plain bursts go down unchanged
        if (!atomic) begin
          down_w.push_back(w_s);
        end
        t = 0;
        #4;
        while (!slv_rsp.w_ready) begin
          t++;
          if (t > Timeout) abort_run("W ready");
          @(negedge clk_i);
          #4;
        end
        @(negedge clk_i);
        w_valid = 1'b0;
        repeat ($urandom % 2) @(negedge clk_i);
      end
    end
  endtask

  task automatic drive_ars(input int n);
    ar_chan_t c;
    int       t;
    for (int i = 0; i < n; i++) begin
      c = ar_list[i];
      exp_r[c.id].push_back({atop_t'(0), c.addr, c.len});
      pending_r++;
      ar_s     = c;
      ar_valid = 1'b1;
      t = 0;
      #4;
      while (!slv_rsp.ar_ready) begin
        t++;
        if (t > Timeout) abort_run("AR ready");
        @(negedge clk_i);
        #4;
      end
      @(negedge clk_i);
      ar_valid = 1'b0;
      repeat ($urandom % 3) @(negedge clk_i);
    end
  endtask

  // Runs the queued lists and waits for every response
  task automatic run_phase();
    int t;
    fork
      drive_aws(aw_list.size());
      drive_ws(aw_list.size());
      drive_ars(ar_list.size());
    join
    t = 0;
    while (pending_b != 0 || pending_r != 0) begin
      @(negedge clk_i);
      t++;
      if (t > Timeout) abort_run("outstanding B and R responses");
    end
    aw_list.delete();
    ar_list.delete();
  endtask

  task automatic add_write(input int id, input atop_t atop, input int len);
    aw_chan_t c;
    c.id   = id_t'(id);
    c.addr = $urandom;
    c.len  = len_t'(len);
    c.atop = atop;
    aw_list.push_back(c);
  endtask

  task automatic add_read(input int id, input int len);
    ar_chan_t c;
    c.id   = id_t'(id);
    c.addr = $urandom;
    c.len  = len_t'(len);
    ar_list.push_back(c);
  endtask

  initial begin
    int kind;
    void'($urandom(32'h97bf_20ee));
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    aw_s      = '0;
    aw_valid  = 1'b0;
    w_s       = '0;
    w_valid   = 1'b0;
    ar_s      = '0;
    ar_valid  = 1'b0;
    b_ready   = 1'b0;
    r_ready   = 1'b0;
    pending_b = 0;
    pending_r = 0;
    errors    = 0;
    for (int i = 0; i < 16; i++) begin
      r_beat[i]      = 0;
      atomic_left[i] = 0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Plain write reaches the subordinate
    aw_before = aw_count;
    add_write(4, 6'h00, 3);
    run_phase();
    if (aw_count != aw_before + 1) begin
      errors++;
      $display("[FAIL] %0t: plain write gave %0d AWs downstream", $time, aw_count - aw_before);
    end

    // Atomic store stays upstream
    aw_before = aw_count;
    add_write(8, 6'h12, 2);
    run_phase();
    if (aw_count != aw_before) begin
      errors++;
      $display("[FAIL] %0t: atomic store reached the master port", $time);
    end

    // Atomic load returns error R beats
    add_write(9, 6'h21, 3);
    run_phase();

    // Plain read burst
    add_read(1, 5);
    run_phase();

    // Long plain bursts back to back, AWs run ahead into the limit
    for (int i = 0; i < 12; i++) begin
      add_write(4 + (i % 4), 6'h00, 15);
    end
    run_phase();

    // Random mix, IDs split by kind
    for (int i = 0; i < 200; i++) begin
      kind = int'($urandom % 4);
      case (kind)
        0: add_read(int'($urandom % 4), int'($urandom % 8));
        1: add_write(4 + int'($urandom % 4), 6'h00, int'($urandom % 8));
        2: add_write(8 + (i % 8), atop_t'(6'h10 + ($urandom % 16)), int'($urandom % 8));
        default: add_write(8 + (i % 8), atop_t'(6'h20 + ($urandom % 32)), int'($urandom % 8));
      endcase
    end
    run_phase();

    $display("errors: %0d in checks, %0d in model", errors, model_errors);
    if (errors == 0 && model_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
rtl/atop_pkg.sv
rtl/write_burst_tracker.sv
rtl/write_atop_ctrl.sv
rtl/read_resp_injector.sv
rtl/atop_filter.sv
testbench/tb_sub_model.sv
testbench/tb_atop_filter.sv

// File: run.sh
#!/bin/sh
# Build and run the atop filter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_atop_filter -o sim_atop_filter \
  && ./obj_dir/sim_atop_filter > sim.log 2>&1 \
  ; cat sim.log \
  && grep -q "all tests passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
